// ==== rtl/pce_pkg.sv ====
/* P-Mesh cache engine definitions */
`default_nettype none

package pce_pkg;

  localparam int PADDR_WIDTH        = 40;
  localparam int DWORD_WIDTH        = 64;
  localparam int BLOCK_WIDTH        = 128;
  localparam int SETS               = 256;
  localparam int INDEX_WIDTH        = 8;
  localparam int BLOCK_OFFSET_WIDTH = 4;
  // Address bits above the index
  localparam int PTAG_WIDTH         = 28;
  // Upper bit of the L1.5 replacement way
  localparam int RPLWAY_ADDR_BIT    = 11;

  typedef logic [PADDR_WIDTH-1:0] paddr_t;
  typedef logic [DWORD_WIDTH-1:0] dword_t;
  typedef logic [BLOCK_WIDTH-1:0] block_t;
  typedef logic [INDEX_WIDTH-1:0] index_t;
  typedef logic                   way_t;
  typedef logic [PTAG_WIDTH-1:0]  ptag_t;
  typedef logic [1:0]             l1rplway_t;

  typedef enum logic [2:0] {
    e_uc_store,
    e_wt_store,
    e_miss_load,
    e_miss_store,
    e_uc_load
  } req_msg_e;

  typedef enum logic [1:0] {
    e_size_1b,
    e_size_2b,
    e_size_4b,
    e_size_8b
  } req_size_e;

  typedef enum logic [1:0] {
    e_load_req,
    e_store_req
  } l15_rqtype_e;

  // Encoding as seen by the L1.5
  typedef enum logic [2:0] {
    e_l15_size_1b = 3'b000,
    e_l15_size_2b = 3'b001,
    e_l15_size_4b = 3'b010,
    e_l15_size_8b = 3'b011
  } l15_size_e;

  typedef enum logic [1:0] {
    e_load_ret,
    e_st_ack,
    e_evict_req,
    e_int_ret
  } l15_rtntype_e;

  typedef enum logic {
    e_data_write,
    e_data_uncached
  } data_op_e;

  typedef enum logic [1:0] {
    e_tag_set_clear,
    e_tag_set_tag,
    e_tag_invalidate
  } tag_op_e;

  typedef enum logic {
    e_stat_set_clear
  } stat_op_e;

endpackage

`default_nettype wire

// ==== rtl/pce_inval_unit.sv ====
/* L1.5 eviction decode */
`timescale 1ns/1ps
`default_nettype none

module pce_inval_unit (
  input  logic                  ret_v_i,
  input  pce_pkg::l15_rtntype_e ret_type_i,
  input  logic [1:0]            ret_inval_way_i,
  input  logic [6:0]            ret_inval_index_i,
  input  logic                  ret_inval_all_i,
  output logic                  inv_tag_v_o,
  output pce_pkg::tag_op_e      inv_tag_op_o,
  output pce_pkg::index_t       inv_tag_index_o,
  output pce_pkg::way_t         inv_tag_way_o,
  input  logic                  inv_tag_yumi_i,
  output logic                  inv_stat_v_o,
  output pce_pkg::stat_op_e     inv_stat_op_o,
  output pce_pkg::index_t       inv_stat_index_o,
  output pce_pkg::way_t         inv_stat_way_o,
  input  logic                  inv_stat_yumi_i,
  output logic                  inv_ret_yumi_o
);
  import pce_pkg::*;

  logic   evict_v;
  index_t inv_index;

  assign evict_v = ret_v_i && (ret_type_i == e_evict_req);

  // Upper L1.5 way bit selects the half of the set space
  assign inv_index = {ret_inval_way_i[1], ret_inval_index_i};

  assign inv_tag_v_o      = evict_v;
  assign inv_tag_op_o     = ret_inval_all_i ? e_tag_set_clear : e_tag_invalidate;
  assign inv_tag_index_o  = inv_index;
  assign inv_tag_way_o    = ret_inval_way_i[0];

  assign inv_stat_v_o     = evict_v && ret_inval_all_i;
  assign inv_stat_op_o    = e_stat_set_clear;
  assign inv_stat_index_o = inv_index;
  assign inv_stat_way_o   = ret_inval_way_i[0];

  // All-way needs both packets taken before the return drains
  assign inv_ret_yumi_o = evict_v && inv_tag_yumi_i && (!ret_inval_all_i || inv_stat_yumi_i);

endmodule

`default_nettype wire

// ==== rtl/pce_tag_arbiter.sv ====
/* Tag and status port arbiter */
`timescale 1ns/1ps
`default_nettype none

module pce_tag_arbiter (
  input  logic              eng_tag_v_i,
  input  pce_pkg::tag_op_e  eng_tag_op_i,
  input  pce_pkg::index_t   eng_tag_index_i,
  input  pce_pkg::way_t     eng_tag_way_i,
  input  pce_pkg::ptag_t    eng_tag_i,
  input  logic              eng_stat_v_i,
  input  pce_pkg::stat_op_e eng_stat_op_i,
  input  pce_pkg::index_t   eng_stat_index_i,
  input  logic              inv_tag_v_i,
  input  pce_pkg::tag_op_e  inv_tag_op_i,
  input  pce_pkg::index_t   inv_tag_index_i,
  input  pce_pkg::way_t     inv_tag_way_i,
  input  logic              inv_stat_v_i,
  input  pce_pkg::stat_op_e inv_stat_op_i,
  input  pce_pkg::index_t   inv_stat_index_i,
  input  pce_pkg::way_t     inv_stat_way_i,
  input  logic              tag_yumi_i,
  input  logic              stat_yumi_i,
  input  logic              eng_ret_yumi_i,
  input  logic              inv_ret_yumi_i,
  output logic              tag_v_o,
  output pce_pkg::tag_op_e  tag_op_o,
  output pce_pkg::index_t   tag_index_o,
  output pce_pkg::way_t     tag_way_o,
  output pce_pkg::ptag_t    tag_o,
  output logic              stat_v_o,
  output pce_pkg::stat_op_e stat_op_o,
  output pce_pkg::index_t   stat_index_o,
  output pce_pkg::way_t     stat_way_o,
  output logic              eng_tag_yumi_o,
  output logic              eng_stat_yumi_o,
  output logic              inv_tag_yumi_o,
  output logic              inv_stat_yumi_o,
  output logic              ret_yumi_o
);
  import pce_pkg::*;

  // Invalidations always win, the engine holds its packet
  assign tag_v_o     = inv_tag_v_i || eng_tag_v_i;
  assign tag_op_o    = inv_tag_v_i ? inv_tag_op_i : eng_tag_op_i;
  assign tag_index_o = inv_tag_v_i ? inv_tag_index_i : eng_tag_index_i;
  assign tag_way_o   = inv_tag_v_i ? inv_tag_way_i : eng_tag_way_i;
  assign tag_o       = inv_tag_v_i ? ptag_t'(0) : eng_tag_i;

  assign stat_v_o     = inv_stat_v_i || eng_stat_v_i;
  assign stat_op_o    = inv_stat_v_i ? inv_stat_op_i : eng_stat_op_i;
  assign stat_index_o = inv_stat_v_i ? inv_stat_index_i : eng_stat_index_i;
  assign stat_way_o   = inv_stat_v_i ? inv_stat_way_i : way_t'(0);

  assign inv_tag_yumi_o  = tag_yumi_i && inv_tag_v_i;
  assign eng_tag_yumi_o  = tag_yumi_i && !inv_tag_v_i;
  assign inv_stat_yumi_o = stat_yumi_i && inv_stat_v_i;
  assign eng_stat_yumi_o = stat_yumi_i && !inv_stat_v_i;

  assign ret_yumi_o = eng_ret_yumi_i || inv_ret_yumi_i;

endmodule

`default_nettype wire

// ==== rtl/pce_req_engine.sv ====
/* P-Mesh request engine */
`timescale 1ns/1ps
`default_nettype none

module pce_req_engine (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_v_i,
  input  pce_pkg::req_msg_e     req_msg_i,
  input  pce_pkg::paddr_t       req_addr_i,
  input  pce_pkg::req_size_e    req_size_i,
  input  pce_pkg::dword_t       req_data_i,
  input  pce_pkg::way_t         req_way_i,
  output logic                  req_ready_o,
  output logic                  req_complete_o,
  input  logic                  l15_ready_i,
  output logic                  l15_v_o,
  output pce_pkg::l15_rqtype_e  l15_rqtype_o,
  output logic                  l15_nc_o,
  output pce_pkg::l15_size_e    l15_size_o,
  output pce_pkg::paddr_t       l15_addr_o,
  output pce_pkg::dword_t       l15_data_o,
  output pce_pkg::l1rplway_t    l15_rplway_o,
  input  logic                  ret_v_i,
  input  pce_pkg::l15_rtntype_e ret_type_i,
  input  logic                  ret_nc_i,
  input  pce_pkg::dword_t       ret_data0_i,
  input  pce_pkg::dword_t       ret_data1_i,
  output logic                  data_v_o,
  output pce_pkg::data_op_e     data_op_o,
  output pce_pkg::index_t       data_index_o,
  output pce_pkg::way_t         data_way_o,
  output pce_pkg::block_t       data_o,
  input  logic                  data_yumi_i,
  output logic                  eng_tag_v_o,
  output pce_pkg::tag_op_e      eng_tag_op_o,
  output pce_pkg::index_t       eng_tag_index_o,
  output pce_pkg::way_t         eng_tag_way_o,
  output pce_pkg::ptag_t        eng_tag_o,
  input  logic                  eng_tag_yumi_i,
  output logic                  eng_stat_v_o,
  output pce_pkg::stat_op_e     eng_stat_op_o,
  output pce_pkg::index_t       eng_stat_index_o,
  input  logic                  eng_stat_yumi_i,
  output logic                  eng_ret_yumi_o
);
  import pce_pkg::*;

  typedef enum logic [2:0] {
    s_reset,
    s_clear,
    s_ready,
    s_send,
    s_uc_wait,
    s_fill_wait
  } state_e;

  state_e    state_r, state_n;
  index_t    set_cnt_r;
  logic      sweep_up;
  logic      is_store, load_take, fsm_ret_yumi;
  logic      load_ret_v, st_ack_v;
  req_msg_e  req_msg_r;
  paddr_t    req_addr_r;
  req_size_e req_size_r;
  way_t      req_way_r;

  // L1.5 is big endian, the cache is little endian
  function automatic dword_t swap_bytes(input dword_t d);
    dword_t r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = d[8*(7-i) +: 8];
    end
    return r;
  endfunction

  function automatic dword_t store_data(input dword_t d, input req_size_e s);
    case (s)
      e_size_1b: return {8{d[7:0]}};
      e_size_2b: return {4{d[7:0], d[15:8]}};
      e_size_4b: return {2{d[7:0], d[15:8], d[23:16], d[31:24]}};
      default:   return swap_bytes(d);
    endcase
  endfunction

  function automatic l15_size_e l15_size(input req_size_e s);
    case (s)
      e_size_1b: return e_l15_size_1b;
      e_size_2b: return e_l15_size_2b;
      e_size_4b: return e_l15_size_4b;
      default:   return e_l15_size_8b;
    endcase
  endfunction

  assign is_store   = (req_msg_i == e_uc_store) || (req_msg_i == e_wt_store);
  assign load_take  = (state_r == s_ready) && req_v_i && l15_ready_i && !is_store;
  assign load_ret_v = ret_v_i && (ret_type_i == e_load_ret);
  assign st_ack_v   = ret_v_i && (ret_type_i == e_st_ack);

  // Store acks drain in every state
  assign eng_ret_yumi_o = fsm_ret_yumi || st_ack_v;

  always_comb begin
    state_n          = state_r;
    req_ready_o      = 1'b0;
    req_complete_o   = 1'b0;
    sweep_up         = 1'b0;
    fsm_ret_yumi     = 1'b0;
    l15_v_o          = 1'b0;
    l15_rqtype_o     = e_load_req;
    l15_nc_o         = 1'b0;
    l15_size_o       = e_l15_size_8b;
    l15_addr_o       = req_addr_r;
    l15_data_o       = '0;
    l15_rplway_o     = {req_addr_r[RPLWAY_ADDR_BIT], req_way_r};
    data_v_o         = 1'b0;
    data_op_o        = e_data_write;
    data_index_o     = req_addr_r[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];
    data_way_o       = req_way_r;
    data_o           = {swap_bytes(ret_data1_i), swap_bytes(ret_data0_i)};
    eng_tag_v_o      = 1'b0;
    eng_tag_op_o     = e_tag_set_tag;
    eng_tag_index_o  = req_addr_r[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];
    eng_tag_way_o    = req_way_r;
    eng_tag_o        = req_addr_r[BLOCK_OFFSET_WIDTH + INDEX_WIDTH +: PTAG_WIDTH];
    eng_stat_v_o     = 1'b0;
    eng_stat_op_o    = e_stat_set_clear;
    eng_stat_index_o = set_cnt_r;

    case (state_r)
      s_reset: begin
        fsm_ret_yumi = ret_v_i && (ret_type_i == e_int_ret);
        if (fsm_ret_yumi) begin
          state_n = s_clear;
        end
      end
      s_clear: begin
        eng_tag_v_o     = 1'b1;
        eng_tag_op_o    = e_tag_set_clear;
        eng_tag_index_o = set_cnt_r;
        eng_tag_way_o   = 1'b0;
        eng_tag_o       = '0;
        eng_stat_v_o    = 1'b1;
        sweep_up        = eng_tag_yumi_i && eng_stat_yumi_i;
        req_complete_o  = sweep_up && (set_cnt_r == index_t'(SETS - 1));
        if (req_complete_o) begin
          state_n = s_ready;
        end
      end
      s_ready: begin
        req_ready_o = l15_ready_i;
        if (req_v_i && is_store) begin
          // Stores pass straight through to the L1.5
          l15_v_o      = l15_ready_i;
          l15_rqtype_o = e_store_req;
          l15_nc_o     = (req_msg_i == e_uc_store);
          l15_size_o   = l15_size(req_size_i);
          l15_addr_o   = req_addr_i;
          l15_data_o   = store_data(req_data_i, req_size_i);
          l15_rplway_o = '0;
        end else if (load_take) begin
          state_n = s_send;
        end
      end
      s_send: begin
        l15_v_o  = l15_ready_i;
        l15_nc_o = (req_msg_r == e_uc_load);
        if (req_msg_r == e_uc_load) begin
          l15_size_o = l15_size(req_size_r);
        end
        if (l15_ready_i) begin
          state_n = l15_nc_o ? s_uc_wait : s_fill_wait;
        end
      end
      s_uc_wait: begin
        if (load_ret_v && ret_nc_i) begin
          data_v_o     = 1'b1;
          data_op_o    = e_data_uncached;
          data_o       = {64'b0, swap_bytes(ret_data0_i)};
          fsm_ret_yumi = data_yumi_i;
          if (fsm_ret_yumi) begin
            state_n = s_ready;
          end
        end
      end
      s_fill_wait: begin
        if (load_ret_v && !ret_nc_i) begin
          data_v_o     = 1'b1;
          eng_tag_v_o  = 1'b1;
          fsm_ret_yumi = data_yumi_i && eng_tag_yumi_i;
          if (fsm_ret_yumi) begin
            state_n = s_ready;
          end
        end
      end
      default: state_n = s_reset;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= s_reset;
      set_cnt_r <= '0;
    end else begin
      state_r <= state_n;
      if (sweep_up) begin
        set_cnt_r <= set_cnt_r + 1'b1;
      end
    end
  end

  // Held for the whole miss or uncached load
  always_ff @(posedge clk_i) begin
    if (load_take) begin
      req_msg_r  <= req_msg_i;
      req_addr_r <= req_addr_i;
      req_size_r <= req_size_i;
      req_way_r  <= req_way_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pce_top.sv ====
/* P-Mesh cache engine */
`timescale 1ns/1ps
`default_nettype none

module pce_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_v_i,
  input  pce_pkg::req_msg_e     req_msg_i,
  input  pce_pkg::paddr_t       req_addr_i,
  input  pce_pkg::req_size_e    req_size_i,
  input  pce_pkg::dword_t       req_data_i,
  input  pce_pkg::way_t         req_way_i,
  output logic                  req_ready_o,
  output logic                  req_complete_o,
  output logic                  data_v_o,
  output pce_pkg::data_op_e     data_op_o,
  output pce_pkg::index_t       data_index_o,
  output pce_pkg::way_t         data_way_o,
  output pce_pkg::block_t       data_o,
  input  logic                  data_yumi_i,
  output logic                  tag_v_o,
  output pce_pkg::tag_op_e      tag_op_o,
  output pce_pkg::index_t       tag_index_o,
  output pce_pkg::way_t         tag_way_o,
  output pce_pkg::ptag_t        tag_o,
  input  logic                  tag_yumi_i,
  output logic                  stat_v_o,
  output pce_pkg::stat_op_e     stat_op_o,
  output pce_pkg::index_t       stat_index_o,
  output pce_pkg::way_t         stat_way_o,
  input  logic                  stat_yumi_i,
  input  logic                  l15_ready_i,
  output logic                  l15_v_o,
  output pce_pkg::l15_rqtype_e  l15_rqtype_o,
  output logic                  l15_nc_o,
  output pce_pkg::l15_size_e    l15_size_o,
  output pce_pkg::paddr_t       l15_addr_o,
  output pce_pkg::dword_t       l15_data_o,
  output pce_pkg::l1rplway_t    l15_rplway_o,
  input  logic                  ret_v_i,
  input  pce_pkg::l15_rtntype_e ret_type_i,
  input  logic                  ret_nc_i,
  input  pce_pkg::dword_t       ret_data0_i,
  input  pce_pkg::dword_t       ret_data1_i,
  input  logic [1:0]            ret_inval_way_i,
  input  logic [6:0]            ret_inval_index_i,
  input  logic                  ret_inval_all_i,
  output logic                  ret_yumi_o
);
  import pce_pkg::*;

  logic     eng_tag_v, eng_tag_yumi, eng_stat_v, eng_stat_yumi, eng_ret_yumi;
  tag_op_e  eng_tag_op;
  index_t   eng_tag_index, eng_stat_index;
  way_t     eng_tag_way;
  ptag_t    eng_tag;
  stat_op_e eng_stat_op;
  logic     inv_tag_v, inv_tag_yumi, inv_stat_v, inv_stat_yumi, inv_ret_yumi;
  tag_op_e  inv_tag_op;
  index_t   inv_tag_index, inv_stat_index;
  way_t     inv_tag_way, inv_stat_way;
  stat_op_e inv_stat_op;

  pce_req_engine u_engine (
    .clk_i, .reset_i,
    .req_v_i, .req_msg_i, .req_addr_i, .req_size_i, .req_data_i, .req_way_i,
    .req_ready_o, .req_complete_o,
    .l15_ready_i, .l15_v_o, .l15_rqtype_o, .l15_nc_o, .l15_size_o,
    .l15_addr_o, .l15_data_o, .l15_rplway_o,
    .ret_v_i, .ret_type_i, .ret_nc_i, .ret_data0_i, .ret_data1_i,
    .data_v_o, .data_op_o, .data_index_o, .data_way_o, .data_o, .data_yumi_i,
    .eng_tag_v_o      (eng_tag_v),
    .eng_tag_op_o     (eng_tag_op),
    .eng_tag_index_o  (eng_tag_index),
    .eng_tag_way_o    (eng_tag_way),
    .eng_tag_o        (eng_tag),
    .eng_tag_yumi_i   (eng_tag_yumi),
    .eng_stat_v_o     (eng_stat_v),
    .eng_stat_op_o    (eng_stat_op),
    .eng_stat_index_o (eng_stat_index),
    .eng_stat_yumi_i  (eng_stat_yumi),
    .eng_ret_yumi_o   (eng_ret_yumi)
  );

  pce_inval_unit u_inval (
    .ret_v_i, .ret_type_i, .ret_inval_way_i, .ret_inval_index_i, .ret_inval_all_i,
    .inv_tag_v_o      (inv_tag_v),
    .inv_tag_op_o     (inv_tag_op),
    .inv_tag_index_o  (inv_tag_index),
    .inv_tag_way_o    (inv_tag_way),
    .inv_tag_yumi_i   (inv_tag_yumi),
    .inv_stat_v_o     (inv_stat_v),
    .inv_stat_op_o    (inv_stat_op),
    .inv_stat_index_o (inv_stat_index),
    .inv_stat_way_o   (inv_stat_way),
    .inv_stat_yumi_i  (inv_stat_yumi),
    .inv_ret_yumi_o   (inv_ret_yumi)
  );

  pce_tag_arbiter u_arbiter (
    .eng_tag_v_i      (eng_tag_v),
    .eng_tag_op_i     (eng_tag_op),
    .eng_tag_index_i  (eng_tag_index),
    .eng_tag_way_i    (eng_tag_way),
    .eng_tag_i        (eng_tag),
    .eng_stat_v_i     (eng_stat_v),
    .eng_stat_op_i    (eng_stat_op),
    .eng_stat_index_i (eng_stat_index),
    .inv_tag_v_i      (inv_tag_v),
    .inv_tag_op_i     (inv_tag_op),
    .inv_tag_index_i  (inv_tag_index),
    .inv_tag_way_i    (inv_tag_way),
    .inv_stat_v_i     (inv_stat_v),
    .inv_stat_op_i    (inv_stat_op),
    .inv_stat_index_i (inv_stat_index),
    .inv_stat_way_i   (inv_stat_way),
    .tag_yumi_i, .stat_yumi_i,
    .eng_ret_yumi_i   (eng_ret_yumi),
    .inv_ret_yumi_i   (inv_ret_yumi),
    .tag_v_o, .tag_op_o, .tag_index_o, .tag_way_o, .tag_o,
    .stat_v_o, .stat_op_o, .stat_index_o, .stat_way_o,
    .eng_tag_yumi_o   (eng_tag_yumi),
    .eng_stat_yumi_o  (eng_stat_yumi),
    .inv_tag_yumi_o   (inv_tag_yumi),
    .inv_stat_yumi_o  (inv_stat_yumi),
    .ret_yumi_o
  );

endmodule

`default_nettype wire

// ==== dv/pce_tb.sv ====
/* P-Mesh cache engine testbench */
`timescale 1ns/1ps
`default_nettype none

module pce_tb;
  import pce_pkg::*;

  // Reset and sweep take about 265 cycles, the directed tests under 100
  localparam int MAX_CYCLES = 2000;

  logic         clk_i, reset_i;
  logic         req_v_i, req_ready_o, req_complete_o;
  req_msg_e     req_msg_i;
  paddr_t       req_addr_i, l15_addr_o;
  req_size_e    req_size_i;
  dword_t       req_data_i, l15_data_o, ret_data0_i, ret_data1_i;
  way_t         req_way_i, data_way_o, tag_way_o, stat_way_o;
  logic         data_v_o, data_yumi_i, tag_v_o, tag_yumi_i, stat_v_o, stat_yumi_i;
  data_op_e     data_op_o;
  index_t       data_index_o, tag_index_o, stat_index_o;
  block_t       data_o;
  tag_op_e      tag_op_o;
  ptag_t        tag_o;
  stat_op_e     stat_op_o;
  logic         l15_ready_i, l15_v_o, l15_nc_o;
  l15_rqtype_e  l15_rqtype_o;
  l15_size_e    l15_size_o;
  l1rplway_t    l15_rplway_o;
  logic         ret_v_i, ret_nc_i, ret_inval_all_i, ret_yumi_o;
  l15_rtntype_e ret_type_i;
  logic [1:0]   ret_inval_way_i;
  logic [6:0]   ret_inval_index_i;
  int           cycle_cnt = 0;

  pce_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic settle();
    #5;
  endtask

  task automatic report_fail(input string what, input logic [127:0] got, input logic [127:0] exp);
    $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    $display("SOME TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_index(input index_t got, input index_t exp, input string what);
    if (got !== exp) report_fail(what, 128'(got), 128'(exp));
  endtask

  task automatic check_block(input block_t got, input block_t exp, input string what);
    if (got !== exp) report_fail(what, got, exp);
  endtask

  task automatic check_dword(input dword_t got, input dword_t exp, input string what);
    if (got !== exp) report_fail(what, 128'(got), 128'(exp));
  endtask

  task automatic check_addr(input paddr_t got, input paddr_t exp, input string what);
    if (got !== exp) report_fail(what, 128'(got), 128'(exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) report_fail(what, 128'(got), 128'(exp));
  endtask

  function automatic dword_t reverse_bytes(input dword_t d);
    return {<<8{d}};
  endfunction

  // Output lane k takes source byte n-1-(k mod n) of the low n bytes
  function automatic dword_t store_lanes(input dword_t d, input int nbytes);
    dword_t r;
    for (int k = 0; k < 8; k++) begin
      r[8*k +: 8] = d[8*(nbytes - 1 - (k % nbytes)) +: 8];
    end
    return r;
  endfunction

  task automatic wait_l15_valid();
    settle();
    while (!l15_v_o) begin
      tick();
      settle();
    end
  endtask

  task automatic evict_during_sweep(input index_t set);
    ret_v_i           = 1'b1;
    ret_type_i        = e_evict_req;
    ret_inval_all_i   = 1'b0;
    ret_inval_way_i   = 2'b11;
    ret_inval_index_i = 7'h15;
    settle();
    check_bit(tag_op_o == e_tag_invalidate, 1'b1, "sweep evict tag op");
    check_index(tag_index_o, 8'h95, "sweep evict tag index");
    check_bit(tag_way_o, 1'b1, "sweep evict tag way");
    check_index(stat_index_o, set, "sweep stat index held");
    check_bit(req_complete_o, 1'b0, "sweep complete during evict");
    check_bit(ret_yumi_o, 1'b1, "sweep evict yumi");
    tick();
    ret_v_i = 1'b0;
  endtask

  task automatic test_init();
    settle();
    check_bit(tag_v_o | stat_v_o | data_v_o | l15_v_o, 1'b0, "valids after reset");
    check_bit(req_ready_o | req_complete_o | ret_yumi_o, 1'b0, "ready after reset");
    tick();
    ret_v_i    = 1'b1;
    ret_type_i = e_int_ret;
    settle();
    check_bit(ret_yumi_o, 1'b1, "int_ret yumi");
    tick();
    ret_v_i     = 1'b0;
    tag_yumi_i  = 1'b1;
    stat_yumi_i = 1'b1;
    for (int i = 0; i < SETS; i++) begin
      // An eviction in mid sweep takes the tag port for one cycle
      if (i == 100) evict_during_sweep(index_t'(i));
      settle();
      check_bit(tag_v_o & stat_v_o, 1'b1, "sweep valids");
      check_bit(tag_op_o == e_tag_set_clear, 1'b1, "sweep tag op");
      check_index(tag_index_o, index_t'(i), "sweep tag index");
      check_index(stat_index_o, index_t'(i), "sweep stat index");
      check_bit(req_complete_o, i == SETS - 1, "sweep complete");
      tick();
    end
    tag_yumi_i  = 1'b0;
    stat_yumi_i = 1'b0;
    settle();
    check_bit(req_ready_o, 1'b1, "ready after sweep");
  endtask

  task automatic do_store(input req_msg_e msg, input req_size_e size);
    int nbytes;
    nbytes     = 1 << int'(size);
    req_v_i    = 1'b1;
    req_msg_i  = msg;
    req_size_i = size;
    req_addr_i = paddr_t'({$urandom, $urandom});
    req_data_i = {$urandom, $urandom};
    settle();
    check_bit(req_ready_o & l15_v_o, 1'b1, "store pass through");
    check_bit(l15_rqtype_o == e_store_req, 1'b1, "store rqtype");
    check_bit(l15_nc_o, msg == e_uc_store, "store nc");
    check_index(index_t'(l15_size_o), index_t'($clog2(nbytes)), "store size code");
    check_addr(l15_addr_o, req_addr_i, "store addr");
    check_dword(l15_data_o, store_lanes(req_data_i, nbytes), "store data");
    tick();
    req_v_i = 1'b0;
  endtask

  task automatic test_stores();
    for (int s = 0; s < 4; s++) begin
      do_store(e_uc_store, req_size_e'(s));
      do_store(e_wt_store, req_size_e'(s));
    end
    l15_ready_i = 1'b0;
    req_v_i     = 1'b1;
    req_msg_i   = e_wt_store;
    repeat (3) begin
      settle();
      check_bit(req_ready_o | l15_v_o, 1'b0, "store under back-pressure");
      tick();
    end
    req_v_i     = 1'b0;
    l15_ready_i = 1'b1;
  endtask

  task automatic issue_load(input req_msg_e msg, input req_size_e size);
    req_v_i    = 1'b1;
    req_msg_i  = msg;
    req_size_i = size;
    req_addr_i = paddr_t'({$urandom, $urandom});
    req_way_i  = way_t'($urandom);
    settle();
    check_bit(req_ready_o, 1'b1, "load ready");
    check_bit(l15_v_o, 1'b0, "load not same cycle");
    tick();
    req_v_i = 1'b0;
    wait_l15_valid();
    check_bit(l15_rqtype_o == e_load_req, 1'b1, "load rqtype");
    check_bit(l15_nc_o, msg == e_uc_load, "load nc");
    check_addr(l15_addr_o, req_addr_i, "load addr");
    check_bit(l15_rplway_o[1], req_addr_i[11], "load rplway addr bit");
    check_bit(l15_rplway_o[0], req_way_i, "load rplway way");
    if (msg != e_uc_load) check_index(index_t'(l15_size_o), 8'd3, "load size code");
    tick();
  endtask

  task automatic test_miss_load();
    issue_load(e_miss_load, e_size_8b);
    ret_v_i     = 1'b1;
    ret_type_i  = e_load_ret;
    ret_nc_i    = 1'b0;
    ret_data0_i = {$urandom, $urandom};
    ret_data1_i = {$urandom, $urandom};
    // Tag port takes the packet, the data port stalls the fill
    tag_yumi_i  = 1'b1;
    repeat (3) begin
      settle();
      check_bit(data_v_o & tag_v_o, 1'b1, "fill valids");
      check_bit(ret_yumi_o, 1'b0, "fill held");
      tick();
    end
    data_yumi_i = 1'b1;
    settle();
    check_bit(data_op_o == e_data_write, 1'b1, "fill data op");
    check_block(data_o, {reverse_bytes(ret_data1_i), reverse_bytes(ret_data0_i)}, "fill data");
    check_index(data_index_o, req_addr_i[11:4], "fill data index");
    check_bit(data_way_o, req_way_i, "fill data way");
    check_bit(tag_op_o == e_tag_set_tag, 1'b1, "fill tag op");
    check_index(tag_index_o, req_addr_i[11:4], "fill tag index");
    check_addr(paddr_t'(tag_o), paddr_t'(req_addr_i[39:12]), "fill ptag");
    check_bit(ret_yumi_o, 1'b1, "fill yumi");
    tick();
    ret_v_i     = 1'b0;
    data_yumi_i = 1'b0;
    tag_yumi_i  = 1'b0;
    settle();
    check_bit(req_ready_o, 1'b1, "ready after fill");
  endtask

  task automatic test_uc_load();
    issue_load(e_uc_load, e_size_4b);
    ret_v_i     = 1'b1;
    ret_type_i  = e_load_ret;
    ret_nc_i    = 1'b1;
    ret_data0_i = {$urandom, $urandom};
    data_yumi_i = 1'b1;
    settle();
    check_bit(data_v_o, 1'b1, "uncached data valid");
    check_bit(data_op_o == e_data_uncached, 1'b1, "uncached data op");
    check_block(data_o, {64'b0, reverse_bytes(ret_data0_i)}, "uncached data");
    check_bit(tag_v_o, 1'b0, "uncached no tag");
    check_bit(ret_yumi_o, 1'b1, "uncached yumi");
    tick();
    ret_v_i     = 1'b0;
    data_yumi_i = 1'b0;
  endtask

  task automatic test_inval();
    ret_v_i           = 1'b1;
    ret_type_i        = e_evict_req;
    ret_inval_all_i   = 1'b0;
    ret_inval_way_i   = 2'b10;
    ret_inval_index_i = 7'($urandom);
    settle();
    check_bit(ret_yumi_o, 1'b0, "evict waits for yumi");
    tag_yumi_i = 1'b1;
    settle();
    check_bit(tag_op_o == e_tag_invalidate, 1'b1, "evict tag op");
    check_index(tag_index_o, {1'b1, ret_inval_index_i}, "evict tag index");
    check_bit(tag_way_o, 1'b0, "evict tag way");
    check_bit(stat_v_o, 1'b0, "evict no stat");
    check_bit(ret_yumi_o, 1'b1, "evict yumi");
    tick();
    ret_inval_all_i = 1'b1;
    ret_inval_way_i = 2'b01;
    settle();
    check_bit(ret_yumi_o, 1'b0, "all-way waits for stat");
    stat_yumi_i = 1'b1;
    settle();
    check_bit(tag_op_o == e_tag_set_clear, 1'b1, "all-way tag op");
    check_bit(stat_v_o & (stat_op_o == e_stat_set_clear), 1'b1, "all-way stat");
    check_index(stat_index_o, {1'b0, ret_inval_index_i}, "all-way stat index");
    check_bit(stat_way_o, 1'b1, "all-way stat way");
    check_bit(ret_yumi_o, 1'b1, "all-way yumi");
    tick();
    ret_v_i     = 1'b0;
    tag_yumi_i  = 1'b0;
    stat_yumi_i = 1'b0;
  endtask

  task automatic test_st_ack();
    ret_v_i    = 1'b1;
    ret_type_i = e_st_ack;
    settle();
    check_bit(ret_yumi_o, 1'b1, "st_ack yumi");
    check_bit(data_v_o | tag_v_o | stat_v_o, 1'b0, "st_ack no packets");
    tick();
    ret_v_i = 1'b0;
  endtask

  initial begin
    void'($urandom(17));
    reset_i           = 1'b1;
    req_v_i           = 1'b0;
    req_msg_i         = e_uc_store;
    req_addr_i        = '0;
    req_size_i        = e_size_1b;
    req_data_i        = '0;
    req_way_i         = 1'b0;
    data_yumi_i       = 1'b0;
    tag_yumi_i        = 1'b0;
    stat_yumi_i       = 1'b0;
    l15_ready_i       = 1'b1;
    ret_v_i           = 1'b0;
    ret_type_i        = e_load_ret;
    ret_nc_i          = 1'b0;
    ret_data0_i       = '0;
    ret_data1_i       = '0;
    ret_inval_way_i   = '0;
    ret_inval_index_i = '0;
    ret_inval_all_i   = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    test_init();
    test_stores();
    test_miss_load();
    test_uc_load();
    test_inval();
    test_st_ack();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== pce.f ====
rtl/pce_pkg.sv
rtl/pce_inval_unit.sv
rtl/pce_tag_arbiter.sv
rtl/pce_req_engine.sv
rtl/pce_top.sv
dv/pce_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pce_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     := pce.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@grep -q "ALL TESTS PASSED" $(LOG) && echo "Simulation passed" || \
	  (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
